//--- all.f
design/csr_pkg.sv
design/csr_counters.sv
design/csr_trap_ctrl.sv
design/pmp_checker.sv
design/csr_regfile.sv
design/csr_unit.sv
sim/tb_csr_unit.sv

//--- design/csr_counters.sv
module csr_counters (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     retired_i,
    input  logic                     write_enable_i,
    input  csr_pkg::csr_addr_e       write_addr_i,
    input  logic [csr_pkg::XLEN-1:0] write_data_i,
    output logic [63:0]              mcycle_o,
    output logic [63:0]              time_o,
    output logic [63:0]              minstret_o,
    output logic [csr_pkg::XLEN-1:0] mcountinhibit_o
);

    logic [63:0]              mcycle_r, time_r, minstret_r;
    logic [63:0]              mcycle_w, time_w, minstret_w;
    logic [csr_pkg::XLEN-1:0] mcountinhibit_r;

    always_comb begin
        mcycle_w   = mcountinhibit_r[0] ? mcycle_r : mcycle_r + 64'd1;
        time_w     = time_r + 64'd1;  // time is never inhibited
        minstret_w = (retired_i && !mcountinhibit_r[2]) ? minstret_r + 64'd1 : minstret_r;

        // written half replaces the count, other half keeps its value
        if (write_enable_i) begin
            case (write_addr_i)
                csr_pkg::CYCLE:    mcycle_w   = {mcycle_r[63:32], write_data_i};
                csr_pkg::CYCLEH:   mcycle_w   = {write_data_i, mcycle_r[31:0]};
                csr_pkg::TIME:     time_w     = {time_r[63:32], write_data_i};
                csr_pkg::TIMEH:    time_w     = {write_data_i, time_r[31:0]};
                csr_pkg::INSTRET:  minstret_w = {minstret_r[63:32], write_data_i};
                csr_pkg::INSTRETH: minstret_w = {write_data_i, minstret_r[31:0]};
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mcycle_r        <= '0;
            time_r          <= '0;
            minstret_r      <= '0;
            mcountinhibit_r <= '0;
        end else begin
            mcycle_r   <= mcycle_w;
            time_r     <= time_w;
            minstret_r <= minstret_w;
            if (write_enable_i && write_addr_i == csr_pkg::MCOUNTINHIBIT)
                mcountinhibit_r <= write_data_i;
        end
    end

    assign mcycle_o        = mcycle_r;
    assign time_o          = time_r;
    assign minstret_o      = minstret_r;
    assign mcountinhibit_o = mcountinhibit_r;

endmodule

//--- design/csr_pkg.sv
package csr_pkg;

    localparam int XLEN = 32;

    // machine and user level CSR addresses used by this core
    typedef enum logic [11:0] {
        MSTATUS       = 12'h300,
        MISA          = 12'h301,
        MIE           = 12'h304,
        MTVEC         = 12'h305,
        MCOUNTINHIBIT = 12'h320,
        MSCRATCH      = 12'h340,
        MEPC          = 12'h341,
        MCAUSE        = 12'h342,
        MIP           = 12'h344,
        PMPCFG0       = 12'h3A0,
        PMPCFG1       = 12'h3A1,
        PMPCFG2       = 12'h3A2,
        PMPADDR0      = 12'h3B0,
        PMPADDR1      = 12'h3B1,
        PMPADDR2      = 12'h3B2,
        PMPADDR3      = 12'h3B3,
        PMPADDR4      = 12'h3B4,
        PMPADDR5      = 12'h3B5,
        PMPADDR6      = 12'h3B6,
        PMPADDR7      = 12'h3B7,
        PMPADDR8      = 12'h3B8,
        MCYCLE        = 12'hB00,
        MINSTRET      = 12'hB02,
        MCYCLEH       = 12'hB80,
        MINSTRETH     = 12'hB82,
        CYCLE         = 12'hC00,
        TIME          = 12'hC01,
        INSTRET       = 12'hC02,
        CYCLEH        = 12'hC80,
        TIMEH         = 12'hC81,
        INSTRETH      = 12'hC82
    } csr_addr_e;

    typedef enum logic [1:0] {
        DIRECT   = 2'd0,
        VECTORED = 2'd1
    } mtvec_mode_e;

    localparam logic [30:0] INT_M_EXTERNAL = 31'd11; // machine external interrupt code

    // MXL = 1 (32 bit), extension I only
    localparam logic [XLEN-1:0] MISA_VALUE = {2'b01, 4'b0000, 26'h000_0100};

    // pmpcfg byte fields
    localparam logic [7:0] PMP_R       = 8'h01;
    localparam logic [7:0] PMP_W       = 8'h02;
    localparam logic [7:0] PMP_X       = 8'h04;
    localparam logic [7:0] PMP_A_OFF   = 8'h00;
    localparam logic [7:0] PMP_A_TOR   = 8'h08;
    localparam logic [7:0] PMP_A_NA4   = 8'h10;
    localparam logic [7:0] PMP_A_NAPOT = 8'h18;
    localparam logic [7:0] PMP_L       = 8'h80;

    localparam int PMP_ENTRIES = 9;

    // word addresses, byte address >> 2
    localparam logic [0:PMP_ENTRIES-1][XLEN-1:0] PMP_ADDR = '{
        32'h0000_0000 >> 2,  // boot rom
        32'h0000_1000 >> 2,
        32'h1000_0000 >> 2,  // system ram
        32'h1000_1000 >> 2,
        32'h2000_0000 >> 2,  // video ram
        32'h2000_1000 >> 2,
        32'hFF00_0004 >> 2,  // seven segment display
        32'hFF00_0008 >> 2,  // switch bank
        32'hFFFF_FFFF >> 2   // rest of the space
    };

    localparam logic [0:PMP_ENTRIES-1][7:0] PMP_CFG = '{
        PMP_L | PMP_A_NAPOT | PMP_R | PMP_X,
        PMP_L | PMP_A_OFF,
        PMP_L | PMP_A_NAPOT | PMP_R | PMP_W,
        PMP_L | PMP_A_OFF,
        PMP_L | PMP_A_NAPOT | PMP_R | PMP_W,
        PMP_L | PMP_A_OFF,
        PMP_L | PMP_A_NA4 | PMP_R | PMP_W,
        PMP_L | PMP_A_NA4 | PMP_R,
        PMP_L | PMP_A_TOR
    };

endpackage

//--- design/csr_regfile.sv
module csr_regfile (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     write_enable_i,
    input  csr_pkg::csr_addr_e       write_addr_i,
    input  logic [csr_pkg::XLEN-1:0] write_data_i,
    input  logic                     read_enable_i,
    input  csr_pkg::csr_addr_e       read_addr_i,
    input  logic                     interrupt_i,
    input  logic                     mstatus_mie_i,
    input  logic                     mstatus_mpie_i,
    input  logic [csr_pkg::XLEN-1:0] mepc_i,
    input  logic [csr_pkg::XLEN-1:0] mcause_i,
    input  logic [63:0]              mcycle_i,
    input  logic [63:0]              time_i,
    input  logic [63:0]              minstret_i,
    input  logic [csr_pkg::XLEN-1:0] mcountinhibit_i,
    output logic [csr_pkg::XLEN-1:0] read_data_o,
    output logic [csr_pkg::XLEN-1:0] mtvec_o,
    output logic                     meie_o
);

    logic [csr_pkg::XLEN-1:0] mtvec_r, mscratch_r, read_data_r;
    logic                     meie_r, mtie_r, msie_r;
    logic [csr_pkg::XLEN-1:0] mstatus_w, mie_w, mip_w;

    assign mstatus_w = {24'b0, mstatus_mpie_i, 3'b0, mstatus_mie_i, 3'b0};
    assign mie_w     = {20'b0, meie_r, 3'b0, mtie_r, 3'b0, msie_r, 3'b0};
    assign mip_w     = {20'b0, interrupt_i, 11'b0};  // no timer or software source

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mtvec_r    <= '0;
            mscratch_r <= '0;
            meie_r     <= 1'b0;
            mtie_r     <= 1'b0;
            msie_r     <= 1'b0;
        end else if (write_enable_i) begin
            case (write_addr_i)
                csr_pkg::MTVEC:    mtvec_r    <= write_data_i;
                csr_pkg::MSCRATCH: mscratch_r <= write_data_i;
                csr_pkg::MIE: begin
                    meie_r <= write_data_i[11];
                    mtie_r <= write_data_i[7];
                    msie_r <= write_data_i[3];
                end
                default: ;  // owned by the counters or trap control
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            read_data_r <= '0;
        end else if (read_enable_i) begin
            case (read_addr_i)
                csr_pkg::MISA:          read_data_r <= csr_pkg::MISA_VALUE;
                csr_pkg::MSTATUS:       read_data_r <= mstatus_w;
                csr_pkg::MTVEC:         read_data_r <= mtvec_r;
                csr_pkg::MIE:           read_data_r <= mie_w;
                csr_pkg::MIP:           read_data_r <= mip_w;
                csr_pkg::MSCRATCH:      read_data_r <= mscratch_r;
                csr_pkg::MEPC:          read_data_r <= mepc_i;
                csr_pkg::MCAUSE:        read_data_r <= mcause_i;
                csr_pkg::MCOUNTINHIBIT: read_data_r <= mcountinhibit_i;
                csr_pkg::CYCLE,
                csr_pkg::MCYCLE:        read_data_r <= mcycle_i[31:0];
                csr_pkg::CYCLEH,
                csr_pkg::MCYCLEH:       read_data_r <= mcycle_i[63:32];
                csr_pkg::TIME:          read_data_r <= time_i[31:0];
                csr_pkg::TIMEH:         read_data_r <= time_i[63:32];
                csr_pkg::INSTRET,
                csr_pkg::MINSTRET:      read_data_r <= minstret_i[31:0];
                csr_pkg::INSTRETH,
                csr_pkg::MINSTRETH:     read_data_r <= minstret_i[63:32];
                // four table bytes per cfg word, entry 0 lowest
                csr_pkg::PMPCFG0: read_data_r <= {csr_pkg::PMP_CFG[3], csr_pkg::PMP_CFG[2],
                                                  csr_pkg::PMP_CFG[1], csr_pkg::PMP_CFG[0]};
                csr_pkg::PMPCFG1: read_data_r <= {csr_pkg::PMP_CFG[7], csr_pkg::PMP_CFG[6],
                                                  csr_pkg::PMP_CFG[5], csr_pkg::PMP_CFG[4]};
                csr_pkg::PMPCFG2: read_data_r <= {24'b0, csr_pkg::PMP_CFG[8]};
                csr_pkg::PMPADDR0: read_data_r <= csr_pkg::PMP_ADDR[0];
                csr_pkg::PMPADDR1: read_data_r <= csr_pkg::PMP_ADDR[1];
                csr_pkg::PMPADDR2: read_data_r <= csr_pkg::PMP_ADDR[2];
                csr_pkg::PMPADDR3: read_data_r <= csr_pkg::PMP_ADDR[3];
                csr_pkg::PMPADDR4: read_data_r <= csr_pkg::PMP_ADDR[4];
                csr_pkg::PMPADDR5: read_data_r <= csr_pkg::PMP_ADDR[5];
                csr_pkg::PMPADDR6: read_data_r <= csr_pkg::PMP_ADDR[6];
                csr_pkg::PMPADDR7: read_data_r <= csr_pkg::PMP_ADDR[7];
                csr_pkg::PMPADDR8: read_data_r <= csr_pkg::PMP_ADDR[8];
                default:           read_data_r <= '0;
            endcase
        end else begin
            read_data_r <= '0;  // idle read port returns zero
        end
    end

    assign read_data_o = read_data_r;
    assign mtvec_o     = mtvec_r;
    assign meie_o      = meie_r;

endmodule

//--- design/csr_trap_ctrl.sv
module csr_trap_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     interrupt_i,
    input  logic [csr_pkg::XLEN-1:0] trap_pc_i,
    input  logic [csr_pkg::XLEN-1:0] mcause_i,
    input  logic                     mtrap_i,
    input  logic                     mret_i,
    input  logic                     jmp_accept_i,
    input  logic                     write_enable_i,
    input  csr_pkg::csr_addr_e       write_addr_i,
    input  logic [csr_pkg::XLEN-1:0] write_data_i,
    input  logic [csr_pkg::XLEN-1:0] mtvec_i,
    input  logic                     meie_i,
    output logic [csr_pkg::XLEN-1:0] jmp_addr_o,
    output logic                     jmp_request_o,
    output logic                     mstatus_mie_o,
    output logic                     mstatus_mpie_o,
    output logic [csr_pkg::XLEN-1:0] mepc_o,
    output logic [csr_pkg::XLEN-1:0] mcause_o
);

    logic                     mstatus_mie_r, mstatus_mpie_r;
    logic [csr_pkg::XLEN-1:0] mepc_r, mcause_r;
    logic                     irq_w;     // enabled external interrupt
    logic                     enter_w;   // trap or interrupt entry
    csr_pkg::mtvec_mode_e     mode_w;

    assign irq_w         = interrupt_i && meie_i && mstatus_mie_r;
    assign enter_w       = mtrap_i || irq_w;
    assign jmp_request_o = enter_w || mret_i;
    assign mode_w        = csr_pkg::mtvec_mode_e'(mtvec_i[1:0]);

    always_comb begin
        if (enter_w) begin
            // a synchronous trap wins over the interrupt vector
            if (mode_w == csr_pkg::VECTORED && irq_w && !mtrap_i)
                jmp_addr_o = {mtvec_i[31:2] + csr_pkg::INT_M_EXTERNAL[29:0], 2'b00};
            else
                jmp_addr_o = {mtvec_i[31:2], 2'b00};
        end else if (mret_i) begin
            jmp_addr_o = mepc_r;
        end else begin
            jmp_addr_o = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mstatus_mie_r  <= 1'b0;
            mstatus_mpie_r <= 1'b0;
            mepc_r         <= '0;
            mcause_r       <= '0;
        end else begin
            // interrupt enable stack
            if (write_enable_i && write_addr_i == csr_pkg::MSTATUS) begin
                mstatus_mie_r  <= write_data_i[3];
                mstatus_mpie_r <= write_data_i[7];
            end else if (jmp_accept_i && enter_w) begin
                mstatus_mie_r  <= 1'b0;
                mstatus_mpie_r <= mstatus_mie_r;
            end else if (jmp_accept_i && mret_i) begin
                mstatus_mie_r  <= mstatus_mpie_r;
                mstatus_mpie_r <= 1'b1;
            end

            if (write_enable_i && write_addr_i == csr_pkg::MEPC)
                mepc_r <= write_data_i;
            else if (jmp_accept_i && enter_w)
                mepc_r <= trap_pc_i;
            else if (jmp_accept_i && mret_i)
                mepc_r <= '0;

            if (jmp_accept_i && mtrap_i)
                mcause_r <= mcause_i;
            else if (jmp_accept_i && irq_w)
                mcause_r <= {1'b1, csr_pkg::INT_M_EXTERNAL};  // interrupt bit + code
            else if (jmp_accept_i && mret_i)
                mcause_r <= '0;
        end
    end

    assign mstatus_mie_o  = mstatus_mie_r;
    assign mstatus_mpie_o = mstatus_mpie_r;
    assign mepc_o         = mepc_r;
    assign mcause_o       = mcause_r;

endmodule

//--- design/csr_unit.sv
module csr_unit (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     retired_i,
    input  logic                     interrupt_i,
    input  logic [csr_pkg::XLEN-1:0] trap_pc_i,
    input  logic [csr_pkg::XLEN-1:0] mcause_i,
    input  logic                     mtrap_i,
    input  logic                     mret_i,
    output logic [csr_pkg::XLEN-1:0] jmp_addr_o,
    output logic                     jmp_request_o,
    input  logic                     jmp_accept_i,
    input  csr_pkg::csr_addr_e       read_addr_i,
    input  logic                     read_enable_i,
    output logic [csr_pkg::XLEN-1:0] read_data_o,
    input  csr_pkg::csr_addr_e       write_addr_i,
    input  logic [csr_pkg::XLEN-1:0] write_data_i,
    input  logic                     write_enable_i,
    input  logic [csr_pkg::XLEN-1:0] lookup1_addr_i,
    output logic [2:0]               lookup1_rwx_o,
    input  logic [csr_pkg::XLEN-1:0] lookup2_addr_i,
    output logic [2:0]               lookup2_rwx_o
);

    logic [63:0]              mcycle, time_cnt, minstret;
    logic [csr_pkg::XLEN-1:0] mcountinhibit, mtvec, mepc, mcause;
    logic                     meie, mstatus_mie, mstatus_mpie;

    csr_counters counters (
        .clk_i, .rst_n_i, .retired_i, .write_enable_i, .write_addr_i, .write_data_i,
        .mcycle_o(mcycle), .time_o(time_cnt), .minstret_o(minstret),
        .mcountinhibit_o(mcountinhibit)
    );

    csr_trap_ctrl trap_ctrl (
        .clk_i, .rst_n_i, .interrupt_i, .trap_pc_i, .mcause_i, .mtrap_i, .mret_i,
        .jmp_accept_i, .write_enable_i, .write_addr_i, .write_data_i,
        .mtvec_i(mtvec), .meie_i(meie),
        .jmp_addr_o, .jmp_request_o,
        .mstatus_mie_o(mstatus_mie), .mstatus_mpie_o(mstatus_mpie),
        .mepc_o(mepc), .mcause_o(mcause)
    );

    csr_regfile regfile (
        .clk_i, .rst_n_i, .write_enable_i, .write_addr_i, .write_data_i,
        .read_enable_i, .read_addr_i, .interrupt_i,
        .mstatus_mie_i(mstatus_mie), .mstatus_mpie_i(mstatus_mpie),
        .mepc_i(mepc), .mcause_i(mcause),
        .mcycle_i(mcycle), .time_i(time_cnt), .minstret_i(minstret),
        .mcountinhibit_i(mcountinhibit),
        .read_data_o, .mtvec_o(mtvec), .meie_o(meie)
    );

    pmp_checker fetch_pmp (.addr_i(lookup1_addr_i), .rwx_o(lookup1_rwx_o));  // instruction side
    pmp_checker data_pmp  (.addr_i(lookup2_addr_i), .rwx_o(lookup2_rwx_o));  // load/store side

endmodule

//--- design/pmp_checker.sv
module pmp_checker (
    input  logic [csr_pkg::XLEN-1:0] addr_i,   // word address
    output logic [2:0]               rwx_o
);

    // later assignments take priority, so the lowest region wins
    always_comb begin
        rwx_o = csr_pkg::PMP_CFG[8][2:0];  // everything above the table

        // single word devices
        if (addr_i == csr_pkg::PMP_ADDR[7])
            rwx_o = csr_pkg::PMP_CFG[7][2:0];
        if (addr_i == csr_pkg::PMP_ADDR[6])
            rwx_o = csr_pkg::PMP_CFG[6][2:0];

        // ordered ranges, entry k covers up to entry k+1
        for (int k = 5; k >= 0; k--) begin
            if (addr_i < csr_pkg::PMP_ADDR[k+1])
                rwx_o = csr_pkg::PMP_CFG[k][2:0];
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_csr_unit -f all.f -o tb_csr_unit
./obj_dir/tb_csr_unit > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation passed"

//--- sim/tb_csr_unit.sv
module tb_csr_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WATCHDOG_CYCLES = 2000;  // summed tests are a few hundred cycles

    logic                     clk_i, rst_n_i, retired_i, interrupt_i;
    logic                     mtrap_i, mret_i, jmp_accept_i;
    logic                     read_enable_i, write_enable_i;
    logic [31:0]              trap_pc_i, mcause_i, write_data_i;
    logic [31:0]              lookup1_addr_i, lookup2_addr_i;
    csr_pkg::csr_addr_e       read_addr_i, write_addr_i;
    logic [31:0]              jmp_addr_o, read_data_o;
    logic                     jmp_request_o;
    logic [2:0]               lookup1_rwx_o, lookup2_rwx_o;

    integer seed;
    int     checks = 0;
    int     errors = 0;
    int     test_errors = 0;
    int     tests = 0;
    string  test_name;

    // region starts as word addresses, rwx with r in bit 0
    logic [31:0] pmp_bound [9] = '{32'h0, 32'h400, 32'h400_0000, 32'h400_0400,
        32'h800_0000, 32'h800_0400, 32'h3FC0_0001, 32'h3FC0_0002, 32'h3FFF_FFFF};
    logic [2:0]  pmp_rwx [9] = '{3'b101, 3'b000, 3'b011, 3'b000, 3'b011, 3'b000,
        3'b011, 3'b001, 3'b000};
    logic [31:0] pmp_edges [17] = '{32'h0, 32'h3FF, 32'h400, 32'h401, 32'h3FF_FFFF,
        32'h400_0000, 32'h400_03FF, 32'h400_0400, 32'h7FF_FFFF, 32'h800_0000,
        32'h800_03FF, 32'h800_0400, 32'h3FC0_0000, 32'h3FC0_0001, 32'h3FC0_0002,
        32'h3FC0_0003, 32'hFFFF_FFFF};

    csr_unit uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic step();
        @(posedge clk_i);
        #2;  // drive point after the edge
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAIL %s (%s) expected %h actual %h", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
        tests++;
    endtask

    task automatic finish_test();
        if (test_errors == 0)
            $display("test %s passed", test_name);
        else
            $display("test %s failed with %0d errors", test_name, test_errors);
    endtask

    task automatic write_csr(input csr_pkg::csr_addr_e addr, input logic [31:0] data);
        write_addr_i = addr;
        write_data_i = data;
        write_enable_i = 1'b1;
        step();
        write_enable_i = 1'b0;
    endtask

    // registered read, data valid one clock later
    task automatic expect_read(input csr_pkg::csr_addr_e addr, input logic [31:0] exp,
                               input string what);
        read_addr_i = addr;
        read_enable_i = 1'b1;
        step();
        read_enable_i = 1'b0;
        check_value(what, exp, read_data_o);
    endtask

    task automatic check_jump(input logic exp_req, input logic [31:0] exp_addr,
                              input string what);
        #1;  // let the combinational path settle
        check_value({what, " request"}, 32'(exp_req), 32'(jmp_request_o));
        check_value({what, " address"}, exp_addr, jmp_addr_o);
    endtask

    // ordered ranges first, then the two single word devices
    function automatic logic [2:0] pmp_model(input logic [31:0] addr);
        logic [2:0] rwx;
        logic       hit;
        rwx = pmp_rwx[8];
        hit = 1'b0;
        for (int k = 0; k < 6; k++) begin
            if (!hit && addr < pmp_bound[k+1]) begin
                rwx = pmp_rwx[k];
                hit = 1'b1;
            end
        end
        if (!hit && addr == pmp_bound[6])
            rwx = pmp_rwx[6];
        else if (!hit && addr == pmp_bound[7])
            rwx = pmp_rwx[7];
        return rwx;
    endfunction

    task automatic check_lookup(input logic [31:0] a1, input logic [31:0] a2);
        lookup1_addr_i = a1;
        lookup2_addr_i = a2;
        #1;
        check_value("fetch lookup", 32'(pmp_model(a1)), 32'(lookup1_rwx_o));
        check_value("data lookup", 32'(pmp_model(a2)), 32'(lookup2_rwx_o));
        step();
    endtask

    initial begin
        logic [31:0] v, base, pc, cause;
        int          n;
        seed = 11229;
        rst_n_i = 1'b0;
        retired_i = 1'b0;
        interrupt_i = 1'b0;
        mtrap_i = 1'b0;
        mret_i = 1'b0;
        jmp_accept_i = 1'b0;
        trap_pc_i = '0;
        mcause_i = '0;
        read_enable_i = 1'b0;
        write_enable_i = 1'b0;
        write_data_i = '0;
        read_addr_i = csr_pkg::MISA;
        write_addr_i = csr_pkg::MISA;
        lookup1_addr_i = '0;
        lookup2_addr_i = '0;
        repeat (8) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;

        start_test("reset");
        check_jump(1'b0, 32'h0, "idle jump");
        expect_read(csr_pkg::MSTATUS, 32'h0, "mstatus");
        expect_read(csr_pkg::MTVEC, 32'h0, "mtvec");
        expect_read(csr_pkg::MSCRATCH, 32'h0, "mscratch");
        expect_read(csr_pkg::MEPC, 32'h0, "mepc");
        expect_read(csr_pkg::MCAUSE, 32'h0, "mcause");
        expect_read(csr_pkg::MISA, 32'h4000_0100, "misa");
        expect_read(csr_pkg::csr_addr_e'(12'h7C0), 32'h0, "unknown address");
        expect_read(csr_pkg::MISA, 32'h4000_0100, "misa again");
        step();
        check_value("idle read port", 32'h0, read_data_o);
        finish_test();

        start_test("write readback");
        v = $random(seed);
        write_csr(csr_pkg::MSCRATCH, v);
        expect_read(csr_pkg::MSCRATCH, v, "mscratch");
        v = $random(seed);
        write_csr(csr_pkg::MTVEC, v);
        expect_read(csr_pkg::MTVEC, v, "mtvec");
        write_csr(csr_pkg::MIE, 32'hFFFF_FFFF);
        expect_read(csr_pkg::MIE, 32'h888, "mie");  // only meie, mtie, msie
        finish_test();

        start_test("counters");
        v = $random(seed);
        n = 3 + int'(v[1:0]);
        write_csr(csr_pkg::CYCLE, v);
        repeat (n) @(posedge clk_i);
        #2;
        expect_read(csr_pkg::CYCLE, v + 32'(n), "cycle count");
        write_csr(csr_pkg::MCOUNTINHIBIT, 32'h1);
        v = $random(seed);
        write_csr(csr_pkg::CYCLE, v);
        expect_read(csr_pkg::CYCLE, v, "inhibited cycle");
        repeat (5) step();
        expect_read(csr_pkg::CYCLE, v, "inhibited cycle later");
        write_csr(csr_pkg::MCOUNTINHIBIT, 32'h0);
        v = $random(seed);
        n = 1 + int'(v[2:0]);
        write_csr(csr_pkg::INSTRET, v);
        repeat (n) begin
            retired_i = 1'b1;
            step();
            retired_i = 1'b0;
            step();
        end
        expect_read(csr_pkg::INSTRET, v + 32'(n), "instret count");
        write_csr(csr_pkg::CYCLE, 32'h0);  // no carry into the high half
        v = $random(seed);
        write_csr(csr_pkg::CYCLEH, v);
        expect_read(csr_pkg::CYCLEH, v, "cycleh");
        finish_test();

        start_test("trap and mret");
        base = $random(seed) & 32'hFFFF_FFFC;  // direct mode
        pc = $random(seed);
        cause = $random(seed) & 32'hF;
        write_csr(csr_pkg::MTVEC, base);
        write_csr(csr_pkg::MSTATUS, 32'h8);
        trap_pc_i = pc;
        mcause_i = cause;
        mtrap_i = 1'b1;
        check_jump(1'b1, base, "trap raised");
        repeat (3) step();
        check_jump(1'b1, base, "trap held");
        expect_read(csr_pkg::MEPC, 32'h0, "mepc before accept");
        expect_read(csr_pkg::MSTATUS, 32'h8, "mstatus before accept");
        jmp_accept_i = 1'b1;
        check_jump(1'b1, base, "trap accepted");
        step();
        mtrap_i = 1'b0;
        jmp_accept_i = 1'b0;
        expect_read(csr_pkg::MEPC, pc, "mepc");
        expect_read(csr_pkg::MCAUSE, cause, "mcause");
        expect_read(csr_pkg::MSTATUS, 32'h80, "mstatus after trap");
        mret_i = 1'b1;
        jmp_accept_i = 1'b1;
        check_jump(1'b1, pc, "mret");
        step();
        mret_i = 1'b0;
        jmp_accept_i = 1'b0;
        check_jump(1'b0, 32'h0, "after mret");
        expect_read(csr_pkg::MSTATUS, 32'h88, "mstatus after mret");
        finish_test();

        start_test("interrupt");
        write_csr(csr_pkg::MSTATUS, 32'h0);
        write_csr(csr_pkg::MIE, 32'h800);
        interrupt_i = 1'b1;
        check_jump(1'b0, 32'h0, "mstatus mie clear");
        write_csr(csr_pkg::MIE, 32'h0);
        write_csr(csr_pkg::MSTATUS, 32'h8);
        check_jump(1'b0, 32'h0, "meie clear");
        base = $random(seed) & 32'hFFFF_FFFC;
        write_csr(csr_pkg::MTVEC, base | 32'h1);  // vectored
        write_csr(csr_pkg::MIE, 32'h800);
        check_jump(1'b1, base + 32'd44, "vectored interrupt");
        pc = $random(seed);
        trap_pc_i = pc;
        jmp_accept_i = 1'b1;
        step();
        jmp_accept_i = 1'b0;
        check_jump(1'b0, 32'h0, "masked after entry");
        expect_read(csr_pkg::MCAUSE, 32'h8000_000B, "mcause");
        expect_read(csr_pkg::MEPC, pc, "mepc");
        expect_read(csr_pkg::MIP, 32'h800, "mip set");
        interrupt_i = 1'b0;
        expect_read(csr_pkg::MIP, 32'h0, "mip clear");
        finish_test();

        start_test("pmp");
        foreach (pmp_edges[i])
            check_lookup(pmp_edges[i], pmp_edges[16-i]);
        repeat (200) begin
            v = $random(seed);
            // second port stays near the low regions
            check_lookup(v >> 2, {4'b0, v[29:28], 12'b0, v[13:0]});
        end
        expect_read(csr_pkg::PMPCFG0, 32'h809B_809D, "pmpcfg0");
        expect_read(csr_pkg::PMPADDR6, 32'h3FC0_0001, "pmpaddr6");
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
